/* files.f */
rtl/sigfmd_pkg.sv
rtl/recip_seed.sv
rtl/nr_iterate.sv
rtl/product_form.sv
rtl/quot_fix.sv
rtl/sigfmd_top.sv
+incdir+test
test/sigfmd_tb.sv

/* rtl/nr_iterate.sv */
`timescale 1ns/1ps

module nr_iterate #(
    parameter int ITER_DP = 3,
    parameter int ITER_SP = 2
) (
    input  logic                          act,
    input  logic                          arst_n,
    input  logic                          seed_vld,
    input  logic [sigfmd_pkg::SIG_W-1:0]  fb_q,
    input  logic                          fdiv_q,
    input  logic                          db_q,
    input  logic [sigfmd_pkg::SEED_W-1:0] seed,
    output logic                          recip_vld,
    output logic [sigfmd_pkg::EXT_W-1:0]  recip,
    output logic                          busy
);

    import sigfmd_pkg::*;

    localparam int ITER_MAX = (ITER_DP > ITER_SP) ? ITER_DP : ITER_SP;
    localparam int CNT_W    = $clog2(ITER_MAX + 1);
    localparam int GUARD_W  = EXT_W - SIG_W;

    logic              running;
    logic              phase;
    logic [CNT_W-1:0]  iter_cnt;
    logic [CNT_W-1:0]  iter_last;
    logic [EXT_W-1:0]  x_q;
    logic [EXT_W-1:0]  bx_q;
    logic [EXT_W-1:0]  x0;
    logic [EXT_W-1:0]  b_ext;
    logic [EXT_W-1:0]  corr;
    logic [EXT_W-1:0]  mul_a;
    logic [PROD_W-1:0] mul_p;
    logic [EXT_W-1:0]  x_next;

    // ------------------------------
    // datapath
    // ------------------------------

    // x is held as 2/b with one integer bit, so it sits in [1, 2).
    assign x0    = {1'b1, seed, {(EXT_W-1-SEED_W){1'b0}}};
    assign b_ext = {fb_q, {GUARD_W{1'b0}}};

    // top product bits of b*x read as b*x/2, so this is 2 - b*x/2.
    assign corr  = ~bx_q + 1'b1;

    // phase 0 forms b*x, phase 1 forms x*corr.
    assign mul_a = phase ? corr : b_ext;
    assign mul_p = mul_a * x_q;

    // saturate near b = 1, where 2/b would not fit.
    assign x_next = mul_p[PROD_W-1] ? {EXT_W{1'b1}} : mul_p[PROD_W-2 -: EXT_W];

    assign iter_last = db_q ? CNT_W'(ITER_DP - 1) : CNT_W'(ITER_SP - 1);

    // ------------------------------
    // iteration control
    // ------------------------------
    always_ff @(posedge act or negedge arst_n) begin
        if (!arst_n) begin
            running   <= 1'b0;
            phase     <= 1'b0;
            iter_cnt  <= '0;
            recip_vld <= 1'b0;
        end else begin
            recip_vld <= 1'b0;
            if (seed_vld) begin
                // a multiply goes straight on.
                running   <= fdiv_q;
                recip_vld <= !fdiv_q;
                phase     <= 1'b0;
                iter_cnt  <= '0;
            end else if (running) begin
                phase <= !phase;
                if (phase) begin
                    if (iter_cnt == iter_last) begin
                        running   <= 1'b0;
                        recip_vld <= 1'b1;
                    end else begin
                        iter_cnt <= iter_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge act) begin
        if (seed_vld) begin
            x_q <= x0;
        end else if (running) begin
            if (phase) begin
                x_q <= x_next;
            end else begin
                bx_q <= mul_p[PROD_W-1 -: EXT_W];
            end
        end
    end

    assign recip = x_q;
    assign busy  = running | recip_vld;

    a_idle_on_seed: assert property (@(posedge act) disable iff (!arst_n)
        seed_vld |-> !running && !recip_vld);

    // db_q is held by stage 1 for the whole loop.
    a_iter_bound: assert property (@(posedge act) disable iff (!arst_n)
        running |-> (iter_cnt <= iter_last) && (iter_cnt < CNT_W'(ITER_MAX)));

endmodule

/* rtl/product_form.sv */
`timescale 1ns/1ps

module product_form (
    input  logic                          act,
    input  logic                          arst_n,
    input  logic                          recip_vld,
    input  logic [sigfmd_pkg::EXT_W-1:0]  recip,
    input  logic [sigfmd_pkg::SIG_W-1:0]  fa_q,
    input  logic [sigfmd_pkg::SIG_W-1:0]  fb_q,
    input  logic                          fdiv_q,
    input  logic                          db_q,
    output logic                          prod_vld,
    output logic [sigfmd_pkg::PROD_W-1:0] prod,
    output logic                          prod_fdiv,
    output logic [sigfmd_pkg::FQ_W-1:0]   fq,
    output logic                          mul_done
);

    import sigfmd_pkg::*;

    localparam int GUARD_W = EXT_W - SIG_W;
    localparam int SP_Q_W  = FQ_W - 1 - SP_DROP_W;
    localparam int LOW_W   = PROD_W - (FQ_W - 1);

    logic [EXT_W-1:0]  a_ext;
    logic [EXT_W-1:0]  b_ext;
    logic [EXT_W-1:0]  mul_b;
    logic [PROD_W-1:0] mul_p;
    logic [PROD_W-1:0] quo_est;
    logic              sticky;

    assign a_ext = {fa_q, {GUARD_W{1'b0}}};
    assign b_ext = {fb_q, {GUARD_W{1'b0}}};

    // a*(2/b) lands the quotient at the same bits as a plain product.
    assign mul_b = fdiv_q ? recip : b_ext;
    assign mul_p = a_ext * mul_b;

    assign sticky = |mul_p[LOW_W-1:0];

    // single precision keeps only its quotient bits.
    assign quo_est = db_q ? mul_p
                          : {mul_p[PROD_W-1 -: SP_Q_W], {(PROD_W-SP_Q_W){1'b0}}};

    always_ff @(posedge act or negedge arst_n) begin
        if (!arst_n) begin
            prod_vld  <= 1'b0;
            mul_done  <= 1'b0;
            prod_fdiv <= 1'b0;
            fq        <= '0;
        end else begin
            prod_vld <= recip_vld && fdiv_q;
            mul_done <= recip_vld && !fdiv_q;
            if (recip_vld) begin
                prod_fdiv <= fdiv_q;
                if (!fdiv_q) begin
                    fq <= {mul_p[PROD_W-1:LOW_W], sticky};
                end
            end
        end
    end

    always_ff @(posedge act) begin
        if (recip_vld && fdiv_q) begin
            prod <= quo_est;
        end
    end

    a_idle_on_recip: assert property (@(posedge act) disable iff (!arst_n)
        recip_vld |-> !prod_vld && !mul_done);

endmodule

/* rtl/quot_fix.sv */
`timescale 1ns/1ps

module quot_fix (
    input  logic                          act,
    input  logic                          arst_n,
    input  logic                          prod_vld,
    input  logic [sigfmd_pkg::PROD_W-1:0] prod,
    input  logic [sigfmd_pkg::SIG_W-1:0]  fa_q,
    input  logic [sigfmd_pkg::SIG_W-1:0]  fb_q,
    input  logic                          db_q,
    output logic [sigfmd_pkg::FQ_W-1:0]   fq,
    output logic                          div_done,
    output logic                          busy
);

    import sigfmd_pkg::*;

    localparam int Q_W       = FQ_W - 1;
    localparam int SP_Q_W    = Q_W - SP_DROP_W;
    localparam int DP_SH     = Q_W - 1;
    localparam int SP_SH     = SP_Q_W - 1;
    localparam int REM_W     = Q_W + SIG_W + 2;
    localparam int MAX_STEPS = 3;
    localparam int STEP_W    = $clog2(MAX_STEPS + 2);

    logic              fixing;
    logic [STEP_W-1:0] steps;
    logic [Q_W-1:0]    q_est;
    logic [Q_W-1:0]    q_q;
    logic [REM_W-1:0]  num;
    logic [REM_W-1:0]  qb;
    logic [REM_W-1:0]  fb_ext;
    logic [REM_W-1:0]  rem_q;
    logic              rem_neg;
    logic              rem_big;
    logic              sticky;
    logic [FQ_W-1:0]   fq_res;

    // ------------------------------
    // remainder
    // ------------------------------
    assign q_est  = db_q ? prod[PROD_W-1 -: Q_W] : Q_W'(prod[PROD_W-1 -: SP_Q_W]);
    assign num    = db_q ? (REM_W'(fa_q) << DP_SH) : (REM_W'(fa_q) << SP_SH);
    assign qb     = REM_W'(q_est) * REM_W'(fb_q);
    assign fb_ext = REM_W'(fb_q);

    // two's complement remainder.
    assign rem_neg = rem_q[REM_W-1];
    assign rem_big = !rem_neg && (rem_q >= fb_ext);
    assign sticky  = |rem_q;

    assign fq_res = db_q ? {q_q, sticky}
                         : {q_q[SP_Q_W-1:0], {SP_DROP_W{1'b0}}, sticky};

    // ------------------------------
    // correction
    // ------------------------------
    always_ff @(posedge act or negedge arst_n) begin
        if (!arst_n) begin
            fixing   <= 1'b0;
            steps    <= '0;
            div_done <= 1'b0;
            fq       <= '0;
        end else begin
            div_done <= 1'b0;
            if (prod_vld) begin
                fixing <= 1'b1;
                steps  <= '0;
            end else if (fixing) begin
                if (rem_neg || rem_big) begin
                    steps <= steps + 1'b1;
                end else begin
                    fixing   <= 1'b0;
                    div_done <= 1'b1;
                    fq       <= fq_res;
                end
            end
        end
    end

    always_ff @(posedge act) begin
        if (prod_vld) begin
            q_q   <= q_est;
            rem_q <= num - qb;
        end else if (fixing) begin
            if (rem_neg) begin
                q_q   <= q_q - 1'b1;
                rem_q <= rem_q + fb_ext;
            end else if (rem_big) begin
                q_q   <= q_q + 1'b1;
                rem_q <= rem_q - fb_ext;
            end
        end
    end

    assign busy = prod_vld | fixing;

    a_idle_on_prod: assert property (@(posedge act) disable iff (!arst_n)
        prod_vld |-> !fixing);

    // bounds the error left by the reciprocal loop.
    a_max_steps: assert property (@(posedge act) disable iff (!arst_n)
        fixing |-> steps <= STEP_W'(MAX_STEPS));

endmodule

/* rtl/recip_seed.sv */
`timescale 1ns/1ps

module recip_seed (
    input  logic                          act,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic [sigfmd_pkg::SIG_W-1:0]  fa,
    input  logic [sigfmd_pkg::SIG_W-1:0]  fb,
    input  logic                          fdiv,
    input  logic                          db,
    output logic                          seed_vld,
    output logic [sigfmd_pkg::SIG_W-1:0]  fa_q,
    output logic [sigfmd_pkg::SIG_W-1:0]  fb_q,
    output logic                          fdiv_q,
    output logic                          db_q,
    output logic [sigfmd_pkg::SEED_W-1:0] seed,
    output logic                          busy
);

    import sigfmd_pkg::*;

    localparam int TBL_N = 1 << SEED_W;

    logic [SEED_W-1:0] seed_tbl [TBL_N];
    logic [SEED_W-1:0] tbl_idx;

    // table contents are constants of the elaboration.
    for (genvar i = 0; i < TBL_N; i++) begin : g_tbl
        assign seed_tbl[i] = seed_of(SEED_W'(i));
    end

    // top fraction bits of the divisor, below the hidden bit.
    assign tbl_idx = fb[SIG_W-2 -: SEED_W];

    always_ff @(posedge act or negedge arst_n) begin
        if (!arst_n) begin
            seed_vld <= 1'b0;
            fdiv_q   <= 1'b0;
            db_q     <= 1'b0;
        end else begin
            seed_vld <= start;
            if (start) begin
                fdiv_q <= fdiv;
                db_q   <= db;
            end
        end
    end

    // operands stay put until the next accepted start.
    always_ff @(posedge act) begin
        if (start) begin
            fa_q <= fa;
            fb_q <= fb;
            seed <= seed_tbl[tbl_idx];
        end
    end

    assign busy = seed_vld;

    // the seed table assumes a normalized divisor.
    a_hidden_bit: assert property (@(posedge act) disable iff (!arst_n)
        start |-> fb[SIG_W-1]);

endmodule

/* rtl/sigfmd_pkg.sv */
package sigfmd_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int SIG_W     = 53;
    localparam int EXT_W     = 58;
    localparam int PROD_W    = 116;
    localparam int FQ_W      = 57;
    localparam int SEED_W    = 8;
    localparam int SP_DROP_W = 29;

    // ------------------------------
    // reciprocal seed
    // ------------------------------

    // rounded fraction of 2/d, d taken at the middle of the index interval.
    // the leading one of the estimate is implied.
    function automatic logic [SEED_W-1:0] seed_of(input logic [SEED_W-1:0] idx);
        int unsigned num;
        int unsigned den;
        int unsigned q2;
        num = 1 << (2 * SEED_W + 3);
        den = (2 << SEED_W) + 1 + 2 * int'(idx);
        q2  = num / den;
        // q2 holds twice the scaled value, so the halving rounds.
        seed_of = SEED_W'((q2 + 1) / 2 - (1 << SEED_W));
    endfunction

endpackage

/* rtl/sigfmd_top.sv */
`timescale 1ns/1ps

module sigfmd_top #(
    parameter int ITER_DP = 3,
    parameter int ITER_SP = 2
) (
    input  logic                         act,
    input  logic                         arst_n,
    input  logic                         start,
    input  logic [sigfmd_pkg::SIG_W-1:0] fa,
    input  logic [sigfmd_pkg::SIG_W-1:0] fb,
    input  logic                         fdiv,
    input  logic                         db,
    output logic [sigfmd_pkg::FQ_W-1:0]  fq,
    output logic                         done,
    output logic                         busy
);

    import sigfmd_pkg::*;

    logic                start_acc;
    logic                seed_vld;
    logic [SIG_W-1:0]    fa_q;
    logic [SIG_W-1:0]    fb_q;
    logic                fdiv_q;
    logic                db_q;
    logic [SEED_W-1:0]   seed;
    logic                busy_seed;
    logic                recip_vld;
    logic [EXT_W-1:0]    recip;
    logic                busy_nr;
    logic                prod_vld;
    logic [PROD_W-1:0]   prod;
    logic                prod_fdiv;
    logic [FQ_W-1:0]     fq_mul;
    logic                mul_done;
    logic [FQ_W-1:0]     fq_div;
    logic                div_done;
    logic                busy_fix;

    // one operation in flight.
    assign start_acc = start & ~busy;

    assign busy = busy_seed | busy_nr | busy_fix;
    assign done = mul_done | div_done;
    assign fq   = prod_fdiv ? fq_div : fq_mul;

    recip_seed u_seed (
        .act      (act),
        .arst_n   (arst_n),
        .start    (start_acc),
        .fa       (fa),
        .fb       (fb),
        .fdiv     (fdiv),
        .db       (db),
        .seed_vld (seed_vld),
        .fa_q     (fa_q),
        .fb_q     (fb_q),
        .fdiv_q   (fdiv_q),
        .db_q     (db_q),
        .seed     (seed),
        .busy     (busy_seed)
    );

    nr_iterate #(
        .ITER_DP (ITER_DP),
        .ITER_SP (ITER_SP)
    ) u_nr (
        .act       (act),
        .arst_n    (arst_n),
        .seed_vld  (seed_vld),
        .fb_q      (fb_q),
        .fdiv_q    (fdiv_q),
        .db_q      (db_q),
        .seed      (seed),
        .recip_vld (recip_vld),
        .recip     (recip),
        .busy      (busy_nr)
    );

    product_form u_prod (
        .act       (act),
        .arst_n    (arst_n),
        .recip_vld (recip_vld),
        .recip     (recip),
        .fa_q      (fa_q),
        .fb_q      (fb_q),
        .fdiv_q    (fdiv_q),
        .db_q      (db_q),
        .prod_vld  (prod_vld),
        .prod      (prod),
        .prod_fdiv (prod_fdiv),
        .fq        (fq_mul),
        .mul_done  (mul_done)
    );

    quot_fix u_fix (
        .act      (act),
        .arst_n   (arst_n),
        .prod_vld (prod_vld),
        .prod     (prod),
        .fa_q     (fa_q),
        .fb_q     (fb_q),
        .db_q     (db_q),
        .fq       (fq_div),
        .div_done (div_done),
        .busy     (busy_fix)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench, the log decides the outcome
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module sigfmd_tb \
    -Mdir obj_dir -o sigfmd_sim > build.log 2>&1 &&
./obj_dir/sigfmd_sim > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "Simulation finished: PASS" sim.log 2> /dev/null &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed, see build.log and sim.log"; exit 1; }

/* test/sigfmd_ref.svh */
`ifndef SIGFMD_REF_SVH
`define SIGFMD_REF_SVH

// top 56 bits of the extended product, then the or of the low 60 bits.
function automatic logic [56:0] mul_result(input logic [52:0] a, input logic [52:0] b);
    logic [115:0] ea;
    logic [115:0] eb;
    logic [115:0] p;
    ea = {58'b0, a, 5'b0};
    eb = {58'b0, b, 5'b0};
    p  = ea * eb;
    return {p[115:60], |p[59:0]};
endfunction

// floor of a * 2^55 / b, sticky when the remainder is nonzero.
function automatic logic [56:0] dp_quotient(input logic [52:0] a, input logic [52:0] b);
    logic [107:0] n;
    logic [107:0] d;
    logic [107:0] q;
    logic [107:0] r;
    n = {a, 55'b0};
    d = {55'b0, b};
    q = n / d;
    r = n % d;
    return {q[55:0], r != 0};
endfunction

// 27 quotient bits on top, zeros below, then the sticky bit.
function automatic logic [56:0] sp_quotient(input logic [52:0] a, input logic [52:0] b);
    logic [78:0] n;
    logic [78:0] d;
    logic [78:0] q;
    logic [78:0] r;
    n = {a, 26'b0};
    d = {26'b0, b};
    q = n / d;
    r = n % d;
    return {q[26:0], 29'b0, r != 0};
endfunction

function automatic logic [56:0] expected_fq(input logic f_div, input logic f_db,
                                            input logic [52:0] a, input logic [52:0] b);
    if (!f_div) begin
        return mul_result(a, b);
    end else if (f_db) begin
        return dp_quotient(a, b);
    end
    return sp_quotient(a, b);
endfunction

`endif

/* test/sigfmd_tb.sv */
`timescale 1ns/1ps

module sigfmd_tb;

    import sigfmd_pkg::*;

    `include "sigfmd_ref.svh"

    logic             act;
    logic             arst_n;
    logic             start;
    logic [SIG_W-1:0] fa;
    logic [SIG_W-1:0] fb;
    logic             fdiv;
    logic             db;
    logic [FQ_W-1:0]  fq;
    logic             done;
    logic             busy;

    integer           seed;
    int               checks;
    int               val_errs;
    int               other_errs;
    int               done_cnt;
    int               accepted;
    logic [FQ_W-1:0]  exp_q[$];

    sigfmd_top u_dut (
        .act    (act),
        .arst_n (arst_n),
        .start  (start),
        .fa     (fa),
        .fb     (fb),
        .fdiv   (fdiv),
        .db     (db),
        .fq     (fq),
        .done   (done),
        .busy   (busy)
    );

    initial begin
        act = 1'b0;
        forever #5 act = ~act;
    end

    // ------------------------------
    // checking
    // ------------------------------
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            val_errs++;
            $display("Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // results come out in issue order.
    always @(negedge act) begin
        if (arst_n && done) begin
            done_cnt++;
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("done pulsed while no operation was outstanding");
            end else begin
                check("fq", fq, exp_q.pop_front());
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic rand_sig(input logic sp, output logic [SIG_W-1:0] v);
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        v = r[SIG_W-1:0];
        v[SIG_W-1] = 1'b1;
        if (sp) begin
            v[SP_DROP_W-1:0] = '0;
        end
    endtask

    // busy is settled 1 ns after the edge, so acceptance is known here.
    task automatic issue(input logic f_div, input logic f_db,
                         input logic [SIG_W-1:0] a, input logic [SIG_W-1:0] b);
        @(posedge act);
        #1;
        fa    = a;
        fb    = b;
        fdiv  = f_div;
        db    = f_db;
        start = 1'b1;
        if (!busy) begin
            exp_q.push_back(expected_fq(f_div, f_db, a, b));
            accepted++;
        end
        @(posedge act);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_all(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || busy) && n < limit) begin
            @(posedge act);
            #1;
            n++;
        end
        if (exp_q.size() != 0 || busy) begin
            other_errs++;
            $display("timeout after %0d cycles, %0d results still outstanding",
                     limit, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic run_ops(input int n, input logic f_div, input logic f_db);
        logic [SIG_W-1:0] a;
        logic [SIG_W-1:0] b;
        for (int k = 0; k < n; k++) begin
            rand_sig(!f_db, a);
            rand_sig(!f_db, b);
            issue(f_div, f_db, a, b);
            wait_all(100);
        end
    endtask

    // edge count from start to done.
    task automatic mul_latency();
        logic [SIG_W-1:0] a;
        logic [SIG_W-1:0] b;
        int               lat;
        rand_sig(1'b0, a);
        rand_sig(1'b0, b);
        @(posedge act);
        #1;
        fa    = a;
        fb    = b;
        fdiv  = 1'b0;
        db    = 1'b1;
        start = 1'b1;
        exp_q.push_back(expected_fq(1'b0, 1'b1, a, b));
        accepted++;
        lat = 0;
        while (lat < 20) begin
            @(posedge act);
            lat++;
            #1;
            start = 1'b0;
            @(negedge act);
            if (done) begin
                break;
            end
        end
        if (!done) begin
            other_errs++;
            $display("timeout waiting for done of the latency multiply");
        end
        check("mul_latency", lat, 3);
    endtask

    initial begin
        logic [SIG_W-1:0] a;
        logic [SIG_W-1:0] b;
        logic [31:0]      r;
        int               acc0;
        int               dn0;
        seed       = 32'he5ad;
        checks     = 0;
        val_errs   = 0;
        other_errs = 0;
        done_cnt   = 0;
        accepted   = 0;
        arst_n     = 1'b0;
        start      = 1'b0;
        fa         = '0;
        fb         = '0;
        fdiv       = 1'b0;
        db         = 1'b0;
        repeat (10) @(posedge act);
        #1;
        arst_n = 1'b1;
        check("done", done, 0);
        check("busy", busy, 0);
        check("fq", fq, 0);

        mul_latency();
        wait_all(50);

        run_ops(40, 1'b0, 1'b1);
        run_ops(40, 1'b0, 1'b0);
        run_ops(60, 1'b1, 1'b1);
        run_ops(60, 1'b1, 1'b0);

        // ------------------------------
        // directed divisions
        // ------------------------------
        rand_sig(1'b0, a);
        issue(1'b1, 1'b1, a, a);
        wait_all(100);
        rand_sig(1'b0, b);
        b[SIG_W-2 -: SEED_W] = '0;
        issue(1'b1, 1'b1, a, b);
        wait_all(100);
        b[SIG_W-2 -: SEED_W] = '1;
        issue(1'b1, 1'b1, a, b);
        wait_all(100);
        issue(1'b1, 1'b1, '1, {1'b1, {(SIG_W-1){1'b0}}});
        wait_all(100);
        issue(1'b1, 1'b1, {1'b1, {(SIG_W-1){1'b0}}}, '1);
        wait_all(100);

        // starts while busy must be dropped.
        acc0 = accepted;
        dn0  = done_cnt;
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            rand_sig(!r[1], a);
            rand_sig(!r[1], b);
            issue(r[0], r[1], a, b);
        end
        wait_all(200);
        repeat (20) @(posedge act);
        #1;
        check("done_count", done_cnt - dn0, accepted - acc0);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
